// File: all.f
+incdir+test
hw/snes_load_pkg.sv
hw/rom_header_detect.sv
hw/ram_clear_seq.sv
hw/cheat_code_assembler.sv
hw/cart_load_top.sv
test/tb_cart_load.sv

// File: Bender.yml
package:
  name: snes_cart_load

sources:
  - files:
      - hw/snes_load_pkg.sv
      - hw/rom_header_detect.sv
      - hw/ram_clear_seq.sv
      - hw/cheat_code_assembler.sv
      - hw/cart_load_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_cart_load.sv

// File: test/tb_util.svh
// ================================================
// Testbench helpers, included inside tb_cart_load.
// Needs clk_sys, clearing, lfsr_state and
// error_count declared ahead of the include.
// ================================================

`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// 16-bit Galois LFSR, one step per bit taken
function automatic logic [15:0] random_word();
	logic [15:0] value;
	int i;
	value = '0;
	for (i = 0; i < 16; i++) begin
		lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 16'hB400 : 16'h0000);
		value = {value[14:0], lfsr_state[0]};
	end
	return value;
endfunction

task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
	if (actual !== expected) begin
		$display("CHECK FAILED at %0t ns: %s = 0x%0h, expected 0x%0h",
			$time, name, actual, expected);
		error_count++;
	end
endtask

task automatic wait_clear_done(input int limit);
	int cycles;
	cycles = 0;
	while (clearing && cycles < limit) begin
		@(posedge clk_sys);
		#10;
		cycles++;
	end
	if (clearing) begin
		$display("Timeout: RAM clear still running after %0d cycles", limit);
		error_count++;
	end
endtask

`endif

// File: test/tb_cart_load.sv
// ================================================
// Directed testbench for cart_load_top with a
// 1024-entry clear sweep. Inputs change 10 ns
// after the rising edge, outputs are read there.
// ================================================

`timescale 1ns/1ps

module tb_cart_load;

	logic clk_sys, reset, io_download, io_wr, pal, clearing, fill_we;
	logic code_load, code_reset, spc_active, core_reset;
	logic [7:0] io_index, rom_type, wram_fill, aram_fill;
	logic [24:0] io_addr;
	logic [15:0] io_data;
	logic [23:0] rom_mask, ram_mask;
	logic [9:0] fill_addr;
	logic [31:0] code_flags, code_addr, code_compare, code_replace;
	snes_load_pkg::header_mode_e header_mode;
	snes_load_pkg::region_sel_e region_sel;
	snes_load_pkg::fill_pattern_e wram_pattern, aram_pattern;
	logic [15:0] lfsr_state;
	int error_count, tests_passed, tests_failed, mark;

	`include "tb_util.svh"

	cart_load_top #(.clear_addr_bits(10)) cart_load_top_i (.*);

	always #50 clk_sys = ~clk_sys;

	function automatic logic [23:0] expected_mask(logic [3:0] size);
		return (24'd1 << (size + 10)) - 24'd1;
	endfunction

	function automatic logic [7:0] expected_fill(snes_load_pkg::fill_pattern_e pattern,
			logic [9:0] addr);
		case (pattern)
			snes_load_pkg::fill_snes2: return (addr[8] != addr[2]) ? 8'h66 : 8'h99;
			snes_load_pkg::fill_snes1: return (addr[9] != addr[0]) ? 8'hFF : 8'h00;
			snes_load_pkg::fill_55: return 8'h55;
			default: return 8'hFF;
		endcase
	endfunction

	// Size word address of each mapping including the copier header
	function automatic logic [24:0] size_word_addr(int map);
		case (map)
			1: return 25'h101D6;
			2: return 25'h4101D6;
			default: return 25'h81D6;
		endcase
	endfunction

	task automatic next_cycle();
		@(posedge clk_sys);
		#10;
	endtask

	task automatic write_word(input logic [24:0] addr, input logic [15:0] data);
		io_addr = addr;
		io_data = data;
		io_wr = 1'b1;
		next_cycle();
		io_wr = 1'b0;
	endtask

	task automatic begin_download(input logic [7:0] index);
		io_index = index;
		io_download = 1'b1;
		next_cycle();
	endtask

	task automatic finish_download();
		io_download = 1'b0;
		next_cycle();
		wait_clear_done(4096);
	endtask

	task automatic report_test(input string name);
		if (error_count == mark) begin
			tests_passed++;
			$display("%s: pass", name);
		end else begin
			tests_failed++;
			$display("%s: fail, %0d errors", name, error_count - mark);
		end
		mark = error_count;
	endtask

	// ================================================
	// Directed tests
	// ================================================
	task automatic reset_values_test();
		check_value("core_reset", core_reset, 1'b1);
		check_value("clearing", clearing, 1'b0);
		check_value("fill_we", fill_we, 1'b0);
		check_value("code_load", code_load, 1'b0);
		check_value("pal", pal, 1'b0);
		check_value("rom_mask", rom_mask, 24'h0);
		check_value("ram_mask", ram_mask, 24'h0);
		report_test("reset_values");
	endtask

	task automatic auto_header_test();
		header_mode = snes_load_pkg::hdr_auto;
		begin_download(8'h00);
		write_word(25'h0, 16'h4A38);
		next_cycle();
		check_value("rom_type", rom_type, 8'h4A);
		check_value("rom_mask", rom_mask, expected_mask(4'h8));
		check_value("ram_mask", ram_mask, expected_mask(4'h3));
		// Zero RAM nibble means no cartridge RAM
		write_word(25'h0, 16'h2107);
		next_cycle();
		check_value("rom_mask", rom_mask, expected_mask(4'h7));
		check_value("ram_mask", ram_mask, 24'h0);
		finish_download();
		report_test("auto_header");
	endtask

	task automatic mapped_header_test(input snes_load_pkg::header_mode_e mode, input int map,
			input logic [3:0] rom_size, input logic [3:0] ram_size);
		int i;
		header_mode = mode;
		begin_download(8'h00);
		write_word(25'h0, 16'hFF3F);
		write_word(size_word_addr(map), {4'h0, rom_size, 8'h00});
		write_word(size_word_addr(map) + 25'd2, {12'h000, ram_size});
		// Other mappings' size words are ignored
		for (i = 0; i < 3; i++) begin
			if (i != map) begin
				write_word(size_word_addr(i), 16'h0F0F);
				write_word(size_word_addr(i) + 25'd2, 16'h0F0F);
			end
		end
		next_cycle();
		check_value("rom_type", rom_type, map);
		check_value("rom_mask", rom_mask, expected_mask(rom_size));
		check_value("ram_mask", ram_mask, expected_mask(ram_size));
		finish_download();
		report_test("mapped_header");
	endtask

	task automatic region_test(input snes_load_pkg::region_sel_e sel,
			input logic expected_before, input logic expected_after);
		region_sel = sel;
		next_cycle();
		begin_download(8'h00);
		check_value("pal", pal, expected_before);
		write_word(25'h2, 16'h0100);
		repeat (4) begin
			check_value("pal", pal, expected_before);
			next_cycle();
		end
		finish_download();
		check_value("pal", pal, expected_after);
		report_test("region_select");
	endtask

	task automatic ram_clear_test(input snes_load_pkg::fill_pattern_e wp,
			input snes_load_pkg::fill_pattern_e ap);
		int writes, cycles;
		wram_pattern = wp;
		aram_pattern = ap;
		begin_download(8'h00);
		check_value("clearing", clearing, 1'b1);
		io_download = 1'b0;
		writes = 0;
		cycles = 0;
		while (clearing && cycles < 4096) begin
			if (fill_we) begin
				check_value("fill_addr", fill_addr, writes);
				check_value("wram_fill", wram_fill, expected_fill(wp, 10'(writes)));
				check_value("aram_fill", aram_fill, expected_fill(ap, 10'(writes)));
				writes++;
			end
			next_cycle();
			cycles++;
		end
		if (clearing) begin
			$display("Timeout: RAM clear did not finish within 4096 cycles");
			error_count++;
		end
		check_value("fill_we count", writes, 1024);
		report_test("ram_clear");
	endtask

	task automatic cheat_code_test();
		logic [15:0] words [8];
		int k, loads;
		loads = 0;
		io_index = 8'hFF;
		io_download = 1'b1;
		for (k = 0; k < 8; k++) begin
			words[k] = random_word();
			io_addr = 25'(2 * k);
			io_data = words[k];
			io_wr = 1'b1;
			#20;
			check_value("code_reset", code_reset, k == 0);
			next_cycle();
			loads += code_load;
		end
		io_wr = 1'b0;
		repeat (4) begin
			next_cycle();
			loads += code_load;
		end
		check_value("code_load pulses", loads, 1);
		check_value("code_flags", code_flags, {words[1], words[0]});
		check_value("code_addr", code_addr, {words[3], words[2]});
		check_value("code_compare", code_compare, {words[5], words[4]});
		check_value("code_replace", code_replace, {words[7], words[6]});
		io_download = 1'b0;
		next_cycle();
		report_test("cheat_code");
	endtask

	task automatic core_reset_test();
		int cycles;
		check_value("core_reset", core_reset, 1'b0);
		io_index = 8'h01;
		io_download = 1'b1;
		#20;
		check_value("spc_active", spc_active, 1'b1);
		check_value("core_reset", core_reset, 1'b1);
		next_cycle();
		io_download = 1'b0;
		repeat (5) next_cycle();
		check_value("core_reset", core_reset, 1'b0);
		io_index = 8'h00;
		io_download = 1'b1;
		#20;
		// Before the clear starts only the download holds the core
		check_value("clearing", clearing, 1'b0);
		check_value("core_reset", core_reset, 1'b1);
		next_cycle();
		check_value("core_reset", core_reset, 1'b1);
		check_value("clearing", clearing, 1'b1);
		io_download = 1'b0;
		cycles = 0;
		while (clearing && cycles < 4096) begin
			check_value("core_reset", core_reset, 1'b1);
			next_cycle();
			cycles++;
		end
		wait_clear_done(16);
		repeat (5) next_cycle();
		check_value("core_reset", core_reset, 1'b0);
		report_test("core_reset");
	endtask

	// ================================================
	// Sequence
	// ================================================
	initial begin
		clk_sys = 1'b0;
		reset = 1'b1;
		io_download = 1'b0;
		io_index = 8'h00;
		io_addr = '0;
		io_data = '0;
		io_wr = 1'b0;
		header_mode = snes_load_pkg::hdr_auto;
		region_sel = snes_load_pkg::region_auto;
		wram_pattern = snes_load_pkg::fill_snes2;
		aram_pattern = snes_load_pkg::fill_snes2;
		lfsr_state = 16'd50040;
		error_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		mark = 0;
		repeat (10) next_cycle();
		reset_values_test();
		reset = 1'b0;
		next_cycle();

		auto_header_test();
		mapped_header_test(snes_load_pkg::hdr_lorom, 0, 4'h9, 4'h3);
		mapped_header_test(snes_load_pkg::hdr_hirom, 1, 4'hA, 4'h5);
		mapped_header_test(snes_load_pkg::hdr_exhirom, 2, 4'hB, 4'h1);
		region_test(snes_load_pkg::region_auto, 1'b0, 1'b1);
		region_test(snes_load_pkg::region_ntsc, 1'b0, 1'b0);
		region_test(snes_load_pkg::region_pal, 1'b1, 1'b1);
		ram_clear_test(snes_load_pkg::fill_snes2, snes_load_pkg::fill_snes1);
		ram_clear_test(snes_load_pkg::fill_snes1, snes_load_pkg::fill_55);
		ram_clear_test(snes_load_pkg::fill_55, snes_load_pkg::fill_ff);
		ram_clear_test(snes_load_pkg::fill_ff, snes_load_pkg::fill_snes2);
		cheat_code_test();
		core_reset_test();

		$display("Summary: %0d passed, %0d failed", tests_passed, tests_failed);
		if (error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: hw/cart_load_top.sv
// ================================================
// Cartridge load control. Classifies the host
// download and drives header, clear and cheat units.
// No back-pressure; clear_addr_bits must be >= 10.
// ================================================

`timescale 1ns/1ps

module cart_load_top #(
	parameter int clear_addr_bits = 18
) (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  logic                                io_download,
	input  logic [7:0]                          io_index,
	input  logic [snes_load_pkg::io_addr_w-1:0] io_addr,
	input  logic [snes_load_pkg::io_data_w-1:0] io_data,
	input  logic                                io_wr,
	input  snes_load_pkg::header_mode_e         header_mode,
	input  snes_load_pkg::region_sel_e          region_sel,
	input  snes_load_pkg::fill_pattern_e        wram_pattern,
	input  snes_load_pkg::fill_pattern_e        aram_pattern,
	output logic [7:0]                          rom_type,
	output logic [snes_load_pkg::mask_w-1:0]    rom_mask,
	output logic [snes_load_pkg::mask_w-1:0]    ram_mask,
	output logic                                pal,
	output logic                                clearing,
	output logic                                fill_we,
	output logic [clear_addr_bits-1:0]          fill_addr,
	output logic [7:0]                          wram_fill,
	output logic [7:0]                          aram_fill,
	output logic [31:0]                         code_flags,
	output logic [31:0]                         code_addr,
	output logic [31:0]                         code_compare,
	output logic [31:0]                         code_replace,
	output logic                                code_load,
	output logic                                code_reset,
	output logic                                spc_active,
	output logic                                core_reset
);

	snes_load_pkg::dl_class_e dl_class;
	logic                     cart_active;
	logic                     code_active;

	// ================================================
	// Download classification
	// ================================================
	always_comb begin
		if (!io_download) begin
			dl_class = snes_load_pkg::dl_none;
		end else if (&io_index) begin
			dl_class = snes_load_pkg::dl_code;
		end else if (io_index[5:0] == 6'h00) begin
			dl_class = snes_load_pkg::dl_cart;
		end else if (io_index[5:0] == 6'h01) begin
			dl_class = snes_load_pkg::dl_spc;
		end else begin
			dl_class = snes_load_pkg::dl_none;
		end
	end

	assign cart_active = (dl_class == snes_load_pkg::dl_cart);
	assign spc_active = (dl_class == snes_load_pkg::dl_spc);
	assign code_active = (dl_class == snes_load_pkg::dl_code);

	// Core held in reset through any load or clear
	assign core_reset = reset | cart_active | spc_active | clearing;

	rom_header_detect rom_header_detect_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cart_active (cart_active),
		.io_wr       (io_wr),
		.io_addr     (io_addr),
		.io_data     (io_data),
		.header_mode (header_mode),
		.region_sel  (region_sel),
		.rom_type    (rom_type),
		.rom_mask    (rom_mask),
		.ram_mask    (ram_mask),
		.pal         (pal)
	);

	ram_clear_seq #(
		.clear_addr_bits (clear_addr_bits)
	) ram_clear_seq_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cart_active  (cart_active),
		.wram_pattern (wram_pattern),
		.aram_pattern (aram_pattern),
		.clearing     (clearing),
		.fill_we      (fill_we),
		.fill_addr    (fill_addr),
		.wram_fill    (wram_fill),
		.aram_fill    (aram_fill)
	);

	cheat_code_assembler cheat_code_assembler_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.code_active  (code_active),
		.cart_active  (cart_active),
		.io_wr        (io_wr),
		.io_addr      (io_addr),
		.io_data      (io_data),
		.code_flags   (code_flags),
		.code_addr    (code_addr),
		.code_compare (code_compare),
		.code_replace (code_replace),
		.code_load    (code_load),
		.code_reset   (code_reset)
	);

endmodule

// File: hw/cheat_code_assembler.sv
// ================================================
// Cheat code collector. Eight words per code at
// offsets 0..14; offset 14 closes the code and
// pulses code_load. Odd offsets are ignored.
// ================================================

`timescale 1ns/1ps

module cheat_code_assembler (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  logic                                code_active,
	input  logic                                cart_active,
	input  logic                                io_wr,
	input  logic [snes_load_pkg::io_addr_w-1:0] io_addr,
	input  logic [snes_load_pkg::io_data_w-1:0] io_data,
	output logic [31:0]                         code_flags,
	output logic [31:0]                         code_addr,
	output logic [31:0]                         code_compare,
	output logic [31:0]                         code_replace,
	output logic                                code_load,
	output logic                                code_reset
);

	logic code_write;

	assign code_write = code_active & io_wr;

	// Word 0 of a new code list or any cart load clears the active codes
	assign code_reset = (code_write && io_addr == '0) || cart_active;

	always_ff @(posedge clk_sys) begin
		if (code_write) begin
			case (io_addr[3:0])
				4'd0:  code_flags[15:0] <= io_data;
				4'd2:  code_flags[31:16] <= io_data;
				4'd4:  code_addr[15:0] <= io_data;
				4'd6:  code_addr[31:16] <= io_data;
				4'd8:  code_compare[15:0] <= io_data;
				4'd10: code_compare[31:16] <= io_data;
				4'd12: code_replace[15:0] <= io_data;
				4'd14: code_replace[31:16] <= io_data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			code_load <= 1'b0;
		end else begin
			code_load <= code_write && io_addr[3:0] == 4'd14;
		end
	end

	code_load_single_pulse: assert property (
		@(posedge clk_sys) disable iff (reset)
		code_load |=> !code_load
	) else $error("code_load held for more than one cycle");

endmodule

// File: hw/ram_clear_seq.sv
// ================================================
// Work/audio RAM clear sweep on cartridge load.
// One write every other cycle, 2**clear_addr_bits
// writes in all. clear_addr_bits must be >= 10.
// ================================================

`timescale 1ns/1ps

module ram_clear_seq #(
	parameter int clear_addr_bits = 18
) (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  logic                               cart_active,
	input  snes_load_pkg::fill_pattern_e       wram_pattern,
	input  snes_load_pkg::fill_pattern_e       aram_pattern,
	output logic                               clearing,
	output logic                               fill_we,
	output logic [clear_addr_bits-1:0]         fill_addr,
	output logic [7:0]                         wram_fill,
	output logic [7:0]                         aram_fill
);

	logic cart_d;
	logic start;
	logic wait_phase;
	logic last_write;

	// Rising edge of the cartridge download
	assign start = cart_active & ~cart_d;

	// Write phase is the first cycle of each pair
	assign fill_we = clearing & ~wait_phase;
	assign last_write = fill_we & (&fill_addr);

	// ================================================
	// Sweep control
	// ================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_d <= 1'b0;
			clearing <= 1'b0;
			wait_phase <= 1'b0;
			fill_addr <= '0;
		end else begin
			cart_d <= cart_active;
			if (start) begin
				// A new download restarts the sweep from zero
				clearing <= 1'b1;
				wait_phase <= 1'b0;
				fill_addr <= '0;
			end else if (clearing) begin
				wait_phase <= ~wait_phase;
				if (wait_phase) begin
					fill_addr <= fill_addr + 1'b1;
				end
				if (last_write) begin
					clearing <= 1'b0;
					wait_phase <= 1'b0;
					fill_addr <= '0;
				end
			end
		end
	end

	// Fill bytes depend only on the low address bits
	assign wram_fill = snes_load_pkg::fill_byte(wram_pattern, fill_addr[9:0]);
	assign aram_fill = snes_load_pkg::fill_byte(aram_pattern, fill_addr[9:0]);

	fill_we_only_when_clearing: assert property (
		@(posedge clk_sys) disable iff (reset)
		fill_we |-> clearing
	) else $error("fill write strobe outside the clear sweep");

	fill_we_alternates: assert property (
		@(posedge clk_sys) disable iff (reset)
		fill_we |=> !fill_we
	) else $error("fill writes on back-to-back cycles");

endmodule

// File: hw/rom_header_detect.sv
// ================================================
// ROM header parser. Only writes seen while
// cart_active is high are decoded. Masks stay zero
// until word 0 of a cartridge has been written.
// ================================================

`timescale 1ns/1ps

module rom_header_detect (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 cart_active,
	input  logic                                 io_wr,
	input  logic [snes_load_pkg::io_addr_w-1:0]  io_addr,
	input  logic [snes_load_pkg::io_data_w-1:0]  io_data,
	input  snes_load_pkg::header_mode_e          header_mode,
	input  snes_load_pkg::region_sel_e           region_sel,
	output logic [7:0]                           rom_type,
	output logic [snes_load_pkg::mask_w-1:0]     rom_mask,
	output logic [snes_load_pkg::mask_w-1:0]     ram_mask,
	output logic                                 pal
);

	logic                                hdr_write;
	logic                                map_en;
	logic [snes_load_pkg::io_addr_w-1:0] map_rom_addr;
	logic [snes_load_pkg::io_addr_w-1:0] map_ram_addr;
	logic [3:0]                          rom_size;
	logic [3:0]                          ram_size;
	logic                                size_valid;
	logic                                rom_region;

	// 1KB shifted by the size code, minus one
	function automatic logic [snes_load_pkg::mask_w-1:0] mask_from_size(logic [3:0] size);
		return (snes_load_pkg::mask_w'(1024) << size) - 1'b1;
	endfunction

	assign hdr_write = cart_active & io_wr;

	// Size word location for the forced mappings
	always_comb begin
		map_en = 1'b1;
		case (header_mode)
			snes_load_pkg::hdr_lorom:   map_rom_addr = snes_load_pkg::hdr_lorom_addr;
			snes_load_pkg::hdr_hirom:   map_rom_addr = snes_load_pkg::hdr_hirom_addr;
			snes_load_pkg::hdr_exhirom: map_rom_addr = snes_load_pkg::hdr_exhirom_addr;
			default: begin
				map_en = 1'b0;
				map_rom_addr = '0;
			end
		endcase
		map_ram_addr = map_rom_addr + snes_load_pkg::hdr_ram_offset;
	end

	// ================================================
	// Size and type capture
	// ================================================
	always_ff @(posedge clk_sys) begin
		if (hdr_write) begin
			if (io_addr == '0) begin
				rom_size <= 4'hC;
				ram_size <= 4'h0;
				// Auto mode takes sizes packed in the low byte
				if (header_mode == snes_load_pkg::hdr_auto && io_data[7:0] != 8'h00) begin
					{ram_size, rom_size} <= io_data[7:0];
				end
				case (header_mode)
					snes_load_pkg::hdr_no_header: rom_type <= 8'd0;
					snes_load_pkg::hdr_lorom:     rom_type <= 8'd0;
					snes_load_pkg::hdr_hirom:     rom_type <= 8'd1;
					snes_load_pkg::hdr_exhirom:   rom_type <= 8'd2;
					default:                      rom_type <= io_data[15:8];
				endcase
			end
			if (map_en && io_addr == map_rom_addr) begin
				rom_size <= io_data[11:8];
			end
			if (map_en && io_addr == map_ram_addr) begin
				ram_size <= io_data[3:0];
			end
		end
	end

	// ================================================
	// Masks and video region
	// ================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			size_valid <= 1'b0;
			rom_region <= 1'b0;
			rom_mask <= '0;
			ram_mask <= '0;
			pal <= 1'b0;
		end else begin
			if (hdr_write && io_addr == '0) begin
				size_valid <= 1'b1;
			end
			if (hdr_write && io_addr == snes_load_pkg::io_addr_w'(2)) begin
				rom_region <= io_data[8];
			end

			rom_mask <= size_valid ? mask_from_size(rom_size) : '0;
			ram_mask <= (size_valid && ram_size != 4'h0) ? mask_from_size(ram_size) : '0;

			// Region only moves between downloads
			if (!cart_active) begin
				if (region_sel == snes_load_pkg::region_auto) begin
					pal <= rom_region;
				end else begin
					pal <= (region_sel == snes_load_pkg::region_pal);
				end
			end
		end
	end

	pal_held_during_load: assert property (
		@(posedge clk_sys) disable iff (reset)
		cart_active && $past(cart_active) |-> $stable(pal)
	) else $error("pal changed during a cartridge download");

endmodule

// File: hw/snes_load_pkg.sv
// ================================================
// Shared widths, enums and ROM header offsets for
// the cartridge load path. Header offsets include
// the 512-byte copier header ahead of the image.
// ================================================

package snes_load_pkg;

	// Download stream and mask widths
	localparam int io_addr_w = 25;
	localparam int io_data_w = 16;
	localparam int mask_w = 24;

	localparam int copier_hdr_bytes = 512;

	// Size word location per mapping, RAM size word sits two bytes later
	localparam logic [io_addr_w-1:0] hdr_lorom_addr = io_addr_w'('h7FD6 + copier_hdr_bytes);
	localparam logic [io_addr_w-1:0] hdr_hirom_addr = io_addr_w'('hFFD6 + copier_hdr_bytes);
	localparam logic [io_addr_w-1:0] hdr_exhirom_addr = io_addr_w'('h40FFD6 + copier_hdr_bytes);
	localparam logic [io_addr_w-1:0] hdr_ram_offset = io_addr_w'(2);

	typedef enum logic [2:0] {
		hdr_auto,
		hdr_no_header,
		hdr_lorom,
		hdr_hirom,
		hdr_exhirom
	} header_mode_e;

	typedef enum logic [1:0] {
		region_auto,
		region_ntsc,
		region_pal
	} region_sel_e;

	typedef enum logic [1:0] {
		dl_none,
		dl_cart,
		dl_spc,
		dl_code
	} dl_class_e;

	typedef enum logic [1:0] {
		fill_snes2,
		fill_snes1,
		fill_55,
		fill_ff
	} fill_pattern_e;

	// Power-on fill byte for one RAM address
	function automatic logic [7:0] fill_byte(fill_pattern_e pattern, logic [9:0] addr);
		logic [7:0] value;
		value = 8'hFF;
		case (pattern)
			fill_snes2: value = (addr[8] ^ addr[2]) ? 8'h66 : 8'h99;
			fill_snes1: value = (addr[9] ^ addr[0]) ? 8'hFF : 8'h00;
			fill_55:    value = 8'h55;
			fill_ff:    value = 8'hFF;
		endcase
		return value;
	endfunction

endpackage
